// ==== logic/link_pkg.sv ====
/*
 * Logic-link endpoint shared definitions
 * Slot layout, debug status word and lane counts
 */
`default_nettype none

package link_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  // Four user channels share one PHY word
  localparam int NUM_LANES  = 4;
  localparam int CHAN_W     = 78;
  // Strobe, marker, then channel data
  localparam int SLOT_W     = 80;
  localparam int PHY_W      = 320;
  // Slots 0 and 1 only in gen1
  localparam int GEN1_LANES = 2;

  //////////////////////////////////////////////////
  // Counters and config
  //////////////////////////////////////////////////

  // Both error counters saturate
  localparam int MRK_CNT_W  = 4;
  localparam int STB_CNT_W  = 8;
  // Online delays and strobe period
  localparam int DELAY_W    = 16;

  // One 80-bit slot on the PHY, stb at the top
  typedef struct packed {
    logic              stb;
    logic              mrk;
    logic [CHAN_W-1:0] data;
  } phy_slot_t;

  // Debug word, lane 0 marker count in the low nibble
  typedef struct packed {
    logic                           tx_up;
    logic                           rx_up;
    logic [5:0]                     rsvd;
    logic [STB_CNT_W-1:0]           stb_err;
    logic [NUM_LANES*MRK_CNT_W-1:0] mrk_err;
  } link_status_t;

  // Received slot plus activity qualifier
  typedef struct packed {
    logic      valid;
    phy_slot_t slot;
  } lane_rx_t;

endpackage

`default_nettype wire

// ==== logic/online_sync.sv ====
/*
 * Online sequencer
 * Delays tx/rx online by programmable counts, makes the periodic strobe
 */
`default_nettype none

module online_sync import link_pkg::*; (
  input  logic               clk_wr,
  input  logic               rst,
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,
  output logic               tx_up,
  output logic               rx_up,
  output logic               tx_stb
);

  // Index 0 is tx, index 1 is rx
  logic [1:0]         online_in;
  logic [DELAY_W-1:0] dly_val [2];
  logic [DELAY_W-1:0] dly_cnt [2];
  logic [1:0]         up_q;
  logic [DELAY_W-1:0] stb_cnt;
  logic               stb_wrap;

  assign online_in  = {rx_online, tx_online};
  assign dly_val[0] = delay_x_value;
  assign dly_val[1] = delay_y_value;

  //////////////////////////////////////////////////
  // Online delay counters
  //////////////////////////////////////////////////

  // Count while online and not yet up, then hold
  // Delay of 0 behaves as 1
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      if (rst || !online_in[i]) begin
        dly_cnt[i] <= '0;
        up_q[i]    <= 1'b0;
      end else if (!up_q[i]) begin
        if ({1'b0, dly_cnt[i]} + 1'b1 >= {1'b0, dly_val[i]}) begin
          up_q[i] <= 1'b1;
        end else begin
          dly_cnt[i] <= dly_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign tx_up = up_q[0];
  assign rx_up = up_q[1];

  //////////////////////////////////////////////////
  // Strobe cadence
  //////////////////////////////////////////////////

  // Period of 0 or 1 keeps the count pinned at zero
  assign stb_wrap = (delay_z_value < DELAY_W'(2)) ||
                    (stb_cnt == delay_z_value - 1'b1);

  // Held at zero while down, so first up cycle strobes
  always_ff @(posedge clk_wr) begin
    if (rst || !up_q[0]) begin
      stb_cnt <= '0;
    end else if (stb_wrap) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  assign tx_stb = up_q[0] && (stb_cnt == '0);

endmodule

`default_nettype wire

// ==== logic/channel_lane.sv ====
/*
 * Channel lane
 * Builds the outgoing slot, captures valid received data, counts lost markers
 */
`default_nettype none

module channel_lane import link_pkg::*; (
  input  logic                 clk_wr,
  input  logic                 rst,
  input  logic                 tx_up,
  input  logic [CHAN_W-1:0]    tx_chan,
  input  lane_rx_t             rx_slot,
  output phy_slot_t            tx_slot,
  output logic [CHAN_W-1:0]    rx_chan,
  output logic [MRK_CNT_W-1:0] mrk_err
);

  logic mrk_miss;
  logic mrk_sat;

  //////////////////////////////////////////////////
  // Transmit
  //////////////////////////////////////////////////

  // Zero slot while offline
  // Strobe is inserted downstream, lane always sends 0
  always_ff @(posedge clk_wr) begin
    if (rst || !tx_up) begin
      tx_slot <= '0;
    end else begin
      tx_slot.stb  <= 1'b0;
      tx_slot.mrk  <= 1'b1;
      tx_slot.data <= tx_chan;
    end
  end

  //////////////////////////////////////////////////
  // Receive
  //////////////////////////////////////////////////

  // Inactive or offline slot reads as zero
  always_ff @(posedge clk_wr) begin
    if (rst || !rx_slot.valid) begin
      rx_chan <= '0;
    end else begin
      rx_chan <= rx_slot.slot.data;
    end
  end

  // Every active slot must carry the marker
  assign mrk_miss = rx_slot.valid && !rx_slot.slot.mrk;
  assign mrk_sat  = &mrk_err;

  // Saturating marker-error count
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      mrk_err <= '0;
    end else if (mrk_miss && !mrk_sat) begin
      mrk_err <= mrk_err + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/phy_concat.sv ====
/*
 * PHY concatenator
 * Packs lane slots into the PHY word with strobe and gen1 masking,
 * unpacks received slots, checks strobe spacing, builds debug status
 */
`default_nettype none

module phy_concat import link_pkg::*; (
  input  logic                 clk_wr,
  input  logic                 rst,
  input  logic                 m_gen2_mode,
  input  logic                 tx_up,
  input  logic                 rx_up,
  input  logic                 tx_stb,
  input  logic [DELAY_W-1:0]   delay_z_value,
  input  phy_slot_t            tx_slot [NUM_LANES],
  input  logic [MRK_CNT_W-1:0] mrk_err [NUM_LANES],
  input  logic [PHY_W-1:0]     rx_phy,
  output logic [PHY_W-1:0]     tx_phy,
  output lane_rx_t             rx_slot [NUM_LANES],
  output link_status_t         status
);

  logic [NUM_LANES-1:0] lane_act;
  logic                 tx_stb_q;
  phy_slot_t            tx_word [NUM_LANES];
  logic [PHY_W-1:0]     rx_phy_q;
  logic                 stb_chk;
  logic                 stb_seen;
  logic                 stb_bad;
  logic [DELAY_W-1:0]   stb_gap;
  logic [STB_CNT_W-1:0] stb_err;

  // All slots in gen2, low slots only in gen1
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_act[i] = m_gen2_mode || (i < GEN1_LANES);
    end
  end

  //////////////////////////////////////////////////
  // Transmit packing
  //////////////////////////////////////////////////

  // Only slot 0 carries the strobe
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      tx_word[i] = tx_slot[i];
      if (i == 0) begin
        tx_word[i].stb = tx_stb_q;
      end
      if (!lane_act[i]) begin
        tx_word[i] = '0;
      end
    end
  end

  // Strobe delayed to line up with the lane register
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_stb_q <= 1'b0;
      tx_phy   <= '0;
    end else begin
      tx_stb_q <= tx_stb;
      for (int i = 0; i < NUM_LANES; i++) begin
        tx_phy[i*SLOT_W +: SLOT_W] <= tx_word[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Receive unpacking
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    rx_phy_q <= rx_phy;
  end

  // Lane 0 in the low slot
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rx_slot[i].valid = rx_up && lane_act[i];
      rx_slot[i].slot  = rx_phy_q[i*SLOT_W +: SLOT_W];
    end
  end

  //////////////////////////////////////////////////
  // Strobe spacing check
  //////////////////////////////////////////////////

  // Check needs a real period
  assign stb_chk = rx_up && (delay_z_value >= DELAY_W'(2));
  // Gap holds cycles since the previous strobe
  assign stb_bad = stb_seen && (stb_gap != delay_z_value);

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      stb_seen <= 1'b0;
      stb_gap  <= '0;
      stb_err  <= '0;
    end else if (!stb_chk) begin
      // Rearm, first strobe after this is not measured
      stb_seen <= 1'b0;
      stb_gap  <= '0;
    end else if (rx_slot[0].slot.stb) begin
      stb_seen <= 1'b1;
      stb_gap  <= DELAY_W'(1);
      if (stb_bad && !(&stb_err)) begin
        stb_err <= stb_err + 1'b1;
      end
    end else if (!(&stb_gap)) begin
      stb_gap <= stb_gap + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Debug status
  //////////////////////////////////////////////////

  always_comb begin
    status.tx_up   = tx_up;
    status.rx_up   = rx_up;
    status.rsvd    = '0;
    status.stb_err = stb_err;
    for (int i = 0; i < NUM_LANES; i++) begin
      status.mrk_err[i*MRK_CNT_W +: MRK_CNT_W] = mrk_err[i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/link_top.sv ====
/*
 * Multi-channel logic-link endpoint
 * Sequencer, four channel lanes and the PHY concatenator
 */
`default_nettype none

module link_top import link_pkg::*; (
  input  logic               clk_wr,
  input  logic               rst,
  // Control
  input  logic               tx_online,
  input  logic               rx_online,
  input  logic               m_gen2_mode,
  input  logic [DELAY_W-1:0] delay_x_value,
  input  logic [DELAY_W-1:0] delay_y_value,
  input  logic [DELAY_W-1:0] delay_z_value,
  // User channels
  input  logic [CHAN_W-1:0]  tx_chan [NUM_LANES],
  output logic [CHAN_W-1:0]  rx_chan [NUM_LANES],
  // PHY
  output logic [PHY_W-1:0]   tx_phy,
  input  logic [PHY_W-1:0]   rx_phy,
  // Debug
  output link_status_t       status
);

  logic                 tx_up;
  logic                 rx_up;
  logic                 tx_stb;
  phy_slot_t            tx_slot [NUM_LANES];
  lane_rx_t             rx_slot [NUM_LANES];
  logic [MRK_CNT_W-1:0] mrk_err [NUM_LANES];

  //////////////////////////////////////////////////
  // Online sequencing
  //////////////////////////////////////////////////

  online_sync online_sync_inst (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .tx_up         (tx_up),
    .rx_up         (rx_up),
    .tx_stb        (tx_stb)
  );

  //////////////////////////////////////////////////
  // Channel lanes
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    channel_lane channel_lane_inst (
      .clk_wr  (clk_wr),
      .rst     (rst),
      .tx_up   (tx_up),
      .tx_chan (tx_chan[i]),
      .rx_slot (rx_slot[i]),
      .tx_slot (tx_slot[i]),
      .rx_chan (rx_chan[i]),
      .mrk_err (mrk_err[i])
    );
  end

  // PHY side of the lane array
  phy_concat phy_concat_inst (
    .clk_wr        (clk_wr),
    .rst           (rst),
    .m_gen2_mode   (m_gen2_mode),
    .tx_up         (tx_up),
    .rx_up         (rx_up),
    .tx_stb        (tx_stb),
    .delay_z_value (delay_z_value),
    .tx_slot       (tx_slot),
    .mrk_err       (mrk_err),
    .rx_phy        (rx_phy),
    .tx_phy        (tx_phy),
    .rx_slot       (rx_slot),
    .status        (status)
  );

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
/*
 * Testbench clock source
 * Free-running clock, period of 8
 */
`default_nettype none

module clk_gen (
  output logic clk
);

  initial clk = 1'b0;

  // Half period of 4
  always #4 clk = ~clk;

endmodule

`default_nettype wire

// ==== verif/link_props.sv ====
/*
 * Link endpoint properties
 * Concurrent checks on the PHY concatenator, bound into phy_concat
 */
`default_nettype none

module link_props import link_pkg::*; (
  input logic             clk_wr,
  input logic             rst,
  input logic             m_gen2_mode,
  input logic             tx_up,
  input logic [PHY_W-1:0] tx_phy,
  input lane_rx_t         rx_slot [NUM_LANES],
  input link_status_t     status
);

  // Number of failed assertions so far
  int fail_count = 0;

  // Lane register plus PHY register, so two cycles of tx_up low
  a_tx_quiet: assert property (@(posedge clk_wr) disable iff (rst)
    (!$past(tx_up, 1) && !$past(tx_up, 2)) |-> (tx_phy == '0))
    else begin
      $error("tx_phy not zero while offline");
      fail_count++;
    end

  // Strobe lives in slot 0 only
  a_stb_slot0: assert property (@(posedge clk_wr) disable iff (rst)
    !(tx_phy[2*SLOT_W-1] || tx_phy[3*SLOT_W-1] || tx_phy[4*SLOT_W-1]))
    else begin
      $error("strobe set outside slot 0");
      fail_count++;
    end

  a_rsvd_zero: assert property (@(posedge clk_wr) disable iff (rst)
    status.rsvd == '0)
    else begin
      $error("status reserved bits not zero");
      fail_count++;
    end

  // Upper slots idle in gen1
  a_gen1_valid: assert property (@(posedge clk_wr) disable iff (rst)
    !m_gen2_mode |-> (!rx_slot[2].valid && !rx_slot[3].valid))
    else begin
      $error("upper lane valid in gen1");
      fail_count++;
    end

endmodule

bind phy_concat link_props link_props_inst (.*);

`default_nettype wire

// ==== verif/link_tb.sv ====
/*
 * Link endpoint testbench
 * Table-driven PHY loopback with marker and strobe fault injection
 */
`default_nettype none

module link_tb import link_pkg::*; ();

  localparam int OFFLINE_CYC = 6;
  localparam int NUM_TESTS   = 7;
  localparam int FAULT_MRK   = 1;
  localparam int FAULT_STB   = 2;

  // One table row
  typedef struct packed {
    logic [95:0]          name;
    logic                 gen2;
    logic [DELAY_W-1:0]   dx;
    logic [DELAY_W-1:0]   dy;
    logic [DELAY_W-1:0]   dz;
    logic [1:0]           fault;
    logic [1:0]           lane;
    logic [7:0]           nfault;
    logic [7:0]           beats;
    logic [MRK_CNT_W-1:0] exp_mrk;
    logic [STB_CNT_W-1:0] exp_stb;
  } test_row_t;

  logic                        clk;
  logic                        rst;
  logic                        tx_online;
  logic                        rx_online;
  logic                        m_gen2_mode;
  logic [DELAY_W-1:0]          delay_x_value;
  logic [DELAY_W-1:0]          delay_y_value;
  logic [DELAY_W-1:0]          delay_z_value;
  logic [CHAN_W-1:0]           tx_chan [NUM_LANES];
  logic [CHAN_W-1:0]           rx_chan [NUM_LANES];
  logic [PHY_W-1:0]            tx_phy;
  logic [PHY_W-1:0]            rx_phy;
  link_status_t                status;

  test_row_t                   table_rows [NUM_TESTS];
  logic [95:0]                 cur_name;
  logic [15:0]                 lfsr_state;
  logic [NUM_LANES*CHAN_W-1:0] hist [$];
  int                          cycles;
  int                          cycle_limit;
  int                          error_count;
  int                          check_count;
  int                          fail_tests;
  int                          test_errors;
  int                          prop_fails;

  clk_gen clk_gen_inst (.clk(clk));

  link_top link_top_inst (
    .clk_wr        (clk),
    .rst           (rst),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .m_gen2_mode   (m_gen2_mode),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .tx_chan       (tx_chan),
    .rx_chan       (rx_chan),
    .tx_phy        (tx_phy),
    .rx_phy        (rx_phy),
    .status        (status)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per channel bit
  task automatic drive_random(output logic [NUM_LANES*CHAN_W-1:0] all);
    for (int i = 0; i < NUM_LANES; i++) begin
      for (int b = 0; b < CHAN_W; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        all[i*CHAN_W+b] = lfsr_state[0];
      end
      tx_chan[i] = all[i*CHAN_W +: CHAN_W];
    end
  endtask

  task automatic check(input string what, input logic [PHY_W-1:0] exp,
                       input logic [PHY_W-1:0] act);
    check_count++;
    if (exp !== act) begin
      $display("mismatch %0s %0s: expected %0h actual %0h", cur_name, what, exp, act);
      error_count++;
      test_errors++;
    end
  endtask

  // name, gen2, dx, dy, dz, fault, lane, n, beats, exp mrk, exp stb
  // rx delay at least tx delay plus 3 so markers arrive before rx_up
  task automatic fill_table();
    table_rows[0] = '{"gen2_basic", 1'b1, 16'd2, 16'd6, 16'd5, 2'd0, 2'd0, 8'd0, 8'd40, 4'd0, 8'd0};
    table_rows[1] = '{"gen1_basic", 1'b0, 16'd0, 16'd4, 16'd4, 2'd0, 2'd0, 8'd0, 8'd40, 4'd0, 8'd0};
    table_rows[2] = '{"mrk_fault", 1'b1, 16'd1, 16'd5, 16'd1, 2'd1, 2'd2, 8'd5, 8'd30, 4'd5, 8'd0};
    table_rows[3] = '{"mrk_sat", 1'b1, 16'd3, 16'd7, 16'd0, 2'd1, 2'd1, 8'd20, 8'd40, 4'd15, 8'd0};
    table_rows[4] = '{"stb_extra", 1'b1, 16'd2, 16'd8, 16'd6, 2'd2, 2'd0, 8'd3, 8'd50, 4'd0, 8'd6};
    table_rows[5] = '{"gen1_stb", 1'b0, 16'd4, 16'd9, 16'd3, 2'd2, 2'd0, 8'd2, 8'd40, 4'd0, 8'd4};
    table_rows[6] = '{"gen1_mrk", 1'b0, 16'd1, 16'd6, 16'd2, 2'd1, 2'd3, 8'd4, 8'd30, 4'd0, 8'd0};
  endtask

  //////////////////////////////////////////////////
  // One table row
  //////////////////////////////////////////////////

  task automatic run_test(input test_row_t t);
    int                          tx_rise;
    int                          rx_rise;
    int                          cyc;
    int                          injected;
    int                          stb_gap;
    int                          active;
    logic                        stb_prev;
    logic [PHY_W-1:0]            word;
    logic [NUM_LANES*CHAN_W-1:0] drv_all;
    logic [NUM_LANES*CHAN_W-1:0] exp_all;
    logic [CHAN_W-1:0]           exp_chan;

    cur_name      = t.name;
    test_errors   = 0;
    hist.delete();
    m_gen2_mode   = t.gen2;
    delay_x_value = t.dx;
    delay_y_value = t.dy;
    delay_z_value = t.dz;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    rst           = 1'b1;
    active        = t.gen2 ? NUM_LANES : GEN1_LANES;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    // Offline, junk on the PHY must not get through
    for (int c = 0; c < OFFLINE_CYC; c++) begin
      drive_random(drv_all);
      rx_phy = '1;
      @(negedge clk);
      check("offline tx_phy", '0, tx_phy);
      for (int i = 0; i < NUM_LANES; i++) begin
        check("offline rx_chan", '0, rx_chan[i]);
      end
    end

    // Count cycles to each up flag
    tx_online = 1'b1;
    rx_online = 1'b1;
    tx_rise   = 0;
    rx_rise   = 0;
    cyc       = 0;
    while (tx_rise == 0 || rx_rise == 0) begin
      @(negedge clk);
      cyc++;
      if (tx_rise == 0 && status.tx_up) tx_rise = cyc;
      if (rx_rise == 0 && status.rx_up) rx_rise = cyc;
      rx_phy = tx_phy;
      drive_random(drv_all);
    end
    check("tx_up delay", (t.dx == 0) ? 1 : t.dx, tx_rise);
    check("rx_up delay", (t.dy == 0) ? 1 : t.dy, rx_rise);

    injected = 0;
    stb_gap  = 0;
    stb_prev = 1'b0;
    for (int b = 0; b < t.beats; b++) begin
      @(negedge clk);
      // Data sent four cycles back
      if (hist.size() == 4) begin
        exp_all = hist.pop_front();
        for (int i = 0; i < NUM_LANES; i++) begin
          exp_chan = (i < active) ? exp_all[i*CHAN_W +: CHAN_W] : {CHAN_W{1'b0}};
          check("rx_chan", exp_chan, rx_chan[i]);
        end
      end
      // Transmit strobe cadence
      if (tx_phy[SLOT_W-1]) begin
        if (stb_gap > 0) check("tx strobe period", (t.dz < 2) ? 1 : t.dz, stb_gap);
        stb_gap = 1;
      end else if (stb_gap > 0) begin
        stb_gap++;
      end
      if (!t.gen2) check("gen1 upper slots", '0, tx_phy[PHY_W-1:GEN1_LANES*SLOT_W]);
      // Loopback copy, with faults
      word = tx_phy;
      if (t.fault == FAULT_MRK && b < t.nfault) begin
        word[t.lane*SLOT_W + CHAN_W] = 1'b0;
      end
      // One extra strobe right after a real one, splits that interval
      if (t.fault == FAULT_STB && injected < t.nfault && stb_prev &&
          b + t.dz + 4 < t.beats) begin
        word[SLOT_W-1] = 1'b1;
        injected++;
      end
      stb_prev = tx_phy[SLOT_W-1];
      rx_phy   = word;
      drive_random(drv_all);
      hist.push_back(drv_all);
    end

    @(negedge clk);
    for (int i = 0; i < NUM_LANES; i++) begin
      check("mrk_err", (t.fault == FAULT_MRK && i == t.lane) ? t.exp_mrk : 0,
            status.mrk_err[i*MRK_CNT_W +: MRK_CNT_W]);
    end
    check("stb_err", t.exp_stb, status.stb_err);
    check("tx_up held", 1, status.tx_up);
    check("rx_up held", 1, status.rx_up);

    // Both flags drop one cycle later
    tx_online = 1'b0;
    rx_online = 1'b0;
    @(negedge clk);
    check("tx_up fall", 0, status.tx_up);
    check("rx_up fall", 0, status.rx_up);

    if (test_errors != 0) fail_tests++;
    $display("test %0s: %0s", cur_name, (test_errors == 0) ? "ok" : "failed");
  endtask

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    rst           = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    m_gen2_mode   = 1'b1;
    delay_x_value = '0;
    delay_y_value = '0;
    delay_z_value = '0;
    rx_phy        = '0;
    for (int i = 0; i < NUM_LANES; i++) tx_chan[i] = '0;
    lfsr_state    = 16'd64500;
    cycles        = 0;
    error_count   = 0;
    check_count   = 0;
    fail_tests    = 0;
    cur_name      = "idle";
    fill_table();
    // Reset, offline, both delays, beats and teardown per row
    cycle_limit = 200;
    for (int n = 0; n < NUM_TESTS; n++) begin
      cycle_limit += 16 + OFFLINE_CYC + table_rows[n].dx + table_rows[n].dy + 2;
      cycle_limit += table_rows[n].beats + 2;
    end
    for (int n = 0; n < NUM_TESTS; n++) begin
      run_test(table_rows[n]);
    end
    prop_fails = link_top_inst.phy_concat_inst.link_props_inst.fail_count;
    $display("tests %0d, failed %0d, checks %0d, mismatches %0d, assertion failures %0d",
             NUM_TESTS, fail_tests, check_count, error_count, prop_fails);
    if (error_count == 0 && prop_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
logic/link_pkg.sv
logic/online_sync.sv
logic/channel_lane.sv
logic/phy_concat.sv
logic/link_top.sv
verif/clk_gen.sv
verif/link_props.sv
verif/link_tb.sv
